// ==== hw/bpredPkg.sv ====
// RV32 only; class vectors are one-hot or zero and opcodes cover the base control-flow encodings
package bpredPkg;

  ////////////////////////////////////////
  // Address width
  ////////////////////////////////////////

  localparam int Xlen = 32;

  typedef logic [Xlen-1:0] pcT;

  ////////////////////////////////////////
  // Instruction class vector
  ////////////////////////////////////////

  // Bit positions inside the 4-bit class
  localparam int ClassCall   = 3;
  localparam int ClassReturn = 2;
  localparam int ClassJump   = 1;
  localparam int ClassBranch = 0;

  // Two-bit saturating direction counter
  // MSB set means predict taken
  typedef enum logic [1:0] {
    StrongNot   = 2'b00,
    WeakNot     = 2'b01,
    WeakTaken   = 2'b10,
    StrongTaken = 2'b11
  } counterT;

  // Major opcodes that change control flow
  // Everything else folds into OpOther
  typedef enum logic [6:0] {
    OpOther  = 7'b0000000,
    OpBranch = 7'b1100011,
    OpJalr   = 7'b1100111,
    OpJal    = 7'b1101111
  } opcodeT;

endpackage

// ==== hw/branchPredictor.sv ====
// Fall-through is always PCPlus4F since compressed code is unsupported; PCD must be the F successor
`timescale 1ns/1ps

module branchPredictor #(
  parameter int DirBits  = 6,
  parameter int BtbBits  = 4,
  parameter int RasDepth = 4
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         StallF, StallD, StallE, StallM,
  input  logic         FlushD, FlushE, FlushM,
  input  logic [31:0]  InstrD,
  input  logic         InstrValidD, InstrValidE,
  input  bpredPkg::pcT PCNextF,
  input  bpredPkg::pcT PCPlus4F,
  input  bpredPkg::pcT PCF, PCD, PCE,
  input  logic         PCSrcE,
  input  bpredPkg::pcT IEUAdrE,
  input  bpredPkg::pcT PCLinkE,
  output bpredPkg::pcT PC1NextF,
  output logic         BPWrongE,
  output logic         BPWrongM, BPDirPredWrongM, BTAWrongM, ClassWrongM,
  output logic [3:0]   ClassM
);
  import bpredPkg::*;

  logic [3:0] ClassE;
  logic [3:0] BTBClassF;
  logic [3:0] predClassD;
  logic [3:0] predClassE;
  pcT         BPBTAF, RASPCF;
  pcT         BPPCF, PC0NextF, PCCorrectE;
  logic       PredReturnF, DirTakenF, BPPCSrcF;
  logic       DirWrongE, TargetWrongE, ClassWrongE, ReturnWrongD;

  ////////////////////////////////////////
  // Predictor blocks
  ////////////////////////////////////////

  instrClassDecode i_instrClassDecode (.clk, .rst, .StallD, .StallE, .StallM,
    .FlushD, .FlushE, .FlushM, .InstrD, .InstrValidD, .PredReturnF,
    .ClassD(), .ClassE, .ClassM, .ReturnWrongD);

  dirPredictor #(.DirBits(DirBits)) i_dirPredictor (.clk, .rst, .StallF, .StallD, .StallE,
    .FlushD, .FlushE, .PCNextF, .PCE, .BranchE(ClassE[ClassBranch]), .InstrValidE,
    .PCSrcE, .DirTakenF, .DirWrongE);

  targetBuffer #(.BtbBits(BtbBits)) i_targetBuffer (.clk, .rst, .StallF, .PCNextF, .PCF,
    .PCE, .IEUAdrE, .ClassE, .InstrValidE, .PCSrcE, .BPBTAF, .BTBClassF, .TargetWrongE);

  returnStack #(.RasDepth(RasDepth)) i_returnStack (.clk, .rst, .StallD, .PredReturnF,
    .ReturnWrongD, .CallE(ClassE[ClassCall]), .InstrValidE, .PCLinkE, .RASPCF);

  ////////////////////////////////////////
  // Next fetch address
  ////////////////////////////////////////

  assign PredReturnF = BTBClassF[ClassReturn];
  assign BPPCF       = PredReturnF ? RASPCF : BPBTAF;
  // Unconditional transfers always redirect, branches only when the counter says taken
  assign BPPCSrcF    = BTBClassF[ClassCall] | BTBClassF[ClassReturn] | BTBClassF[ClassJump]
                     | (BTBClassF[ClassBranch] & DirTakenF);
  assign PC0NextF    = BPPCSrcF ? BPPCF : PCPlus4F;

  // Resolved address of the E instruction
  assign PCCorrectE = PCSrcE ? IEUAdrE : PCLinkE;
  assign BPWrongE   = (PCCorrectE != PCD) & InstrValidE & InstrValidD;
  assign PC1NextF   = BPWrongE ? PCCorrectE : PC0NextF;

  // Class that F acted on, carried to E
  always_ff @(posedge clk) begin
    if (rst | FlushD)
      predClassD <= 4'b0000;
    else if (~StallD)
      predClassD <= BTBClassF;
  end

  always_ff @(posedge clk) begin
    if (rst | FlushE)
      predClassE <= 4'b0000;
    else if (~StallE)
      predClassE <= predClassD;
  end

  assign ClassWrongE = InstrValidE & (predClassE != ClassE);

  // M-stage report
  always_ff @(posedge clk) begin
    if (rst | FlushM) begin
      BPWrongM        <= 1'b0;
      BPDirPredWrongM <= 1'b0;
      BTAWrongM       <= 1'b0;
      ClassWrongM     <= 1'b0;
    end else if (~StallM) begin
      BPWrongM        <= BPWrongE;
      BPDirPredWrongM <= DirWrongE;
      BTAWrongM       <= TargetWrongE;
      ClassWrongM     <= ClassWrongE;
    end
  end

  // Direction report in M belongs to a branch decoded two stages earlier
  assert property (@(posedge clk) disable iff (rst) BPDirPredWrongM |-> ClassM[ClassBranch])
    else $error("Direction wrong reported for non-branch class %b", ClassM);

endmodule

// ==== hw/dirPredictor.sv ====
// Untagged table indexed by PC[DirBits+1:2]; aliased branches share and train one counter
`timescale 1ns/1ps

module dirPredictor #(
  parameter int DirBits = 6
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         StallF, StallD, StallE,
  input  logic         FlushD, FlushE,
  input  bpredPkg::pcT PCNextF,
  input  bpredPkg::pcT PCE,
  input  logic         BranchE,
  input  logic         InstrValidE,
  input  logic         PCSrcE,
  output logic         DirTakenF,
  output logic         DirWrongE
);
  import bpredPkg::*;

  localparam int Entries = 1 << DirBits;

  counterT            ctrTable [Entries];
  counterT            ctrF;
  counterT            ctrNextE;
  logic [DirBits-1:0] idxNextF;
  logic [DirBits-1:0] idxE;
  logic               takenD;
  logic               takenE;
  logic               trainE;

  // Word index, low two bits are always zero
  assign idxNextF = PCNextF[DirBits+1:2];
  assign idxE     = PCE[DirBits+1:2];

  // Registered read, data lines up with PCF
  always_ff @(posedge clk) begin
    if (rst)
      ctrF <= WeakNot;
    else if (~StallF)
      ctrF <= ctrTable[idxNextF];
  end

  assign DirTakenF = ctrF[1];

  // Carry the prediction along so E can check it
  always_ff @(posedge clk) begin
    if (rst | FlushD)
      takenD <= 1'b0;
    else if (~StallD)
      takenD <= DirTakenF;
  end

  always_ff @(posedge clk) begin
    if (rst | FlushE)
      takenE <= 1'b0;
    else if (~StallE)
      takenE <= takenD;
  end

  assign DirWrongE = InstrValidE & BranchE & (takenE != PCSrcE);

  ////////////////////////////////////////
  // Training at E
  ////////////////////////////////////////

  assign trainE = InstrValidE & BranchE & ~StallE;

  // Step one state toward the outcome, saturating at both ends
  always_comb begin
    case (ctrTable[idxE])
      StrongNot:   ctrNextE = PCSrcE ? WeakNot     : StrongNot;
      WeakNot:     ctrNextE = PCSrcE ? WeakTaken   : StrongNot;
      WeakTaken:   ctrNextE = PCSrcE ? StrongTaken : WeakNot;
      StrongTaken: ctrNextE = PCSrcE ? StrongTaken : WeakTaken;
      default:     ctrNextE = WeakNot;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < Entries; i++) begin
        ctrTable[i] <= WeakNot;
      end
    end else if (trainE) begin
      ctrTable[idxE] <= ctrNextE;
    end
  end

endmodule

// ==== hw/instrClassDecode.sv ====
// Decodes RV32 base encodings only; class registers follow stall and flush, flush winning
`timescale 1ns/1ps

module instrClassDecode (
  input  logic        clk,
  input  logic        rst,
  input  logic        StallD, StallE, StallM,
  input  logic        FlushD, FlushE, FlushM,
  input  logic [31:0] InstrD,
  input  logic        InstrValidD,
  input  logic        PredReturnF,
  output logic [3:0]  ClassD,
  output logic [3:0]  ClassE,
  output logic [3:0]  ClassM,
  output logic        ReturnWrongD
);
  import bpredPkg::*;

  opcodeT     opD;
  logic [4:0] rdD;
  logic [4:0] rs1D;
  logic       jumpOpD;
  logic       callD;
  logic       returnD;
  logic       predReturnD;

  ////////////////////////////////////////
  // D-stage decode
  ////////////////////////////////////////

  assign rdD  = InstrD[11:7];
  assign rs1D = InstrD[19:15];

  // Fold the opcode field onto the few encodings we care about
  always_comb begin
    case (InstrD[6:0])
      OpBranch: opD = OpBranch;
      OpJal:    opD = OpJal;
      OpJalr:   opD = OpJalr;
      default:  opD = OpOther;
    endcase
  end

  assign jumpOpD = (opD == OpJal) | (opD == OpJalr);
  // Link written to ra
  assign callD   = jumpOpD & (rdD == 5'd1);
  // jalr x0, 0(ra)
  assign returnD = (opD == OpJalr) & (rs1D == 5'd1) & (rdD == 5'd0);

  always_comb begin
    ClassD              = 4'b0000;
    ClassD[ClassCall]   = callD;
    ClassD[ClassReturn] = returnD;
    ClassD[ClassJump]   = jumpOpD & ~callD & ~returnD;
    ClassD[ClassBranch] = (opD == OpBranch);
  end

  ////////////////////////////////////////
  // Class pipe and return check
  ////////////////////////////////////////

  // F thought this was a return
  always_ff @(posedge clk) begin
    if (rst | FlushD)
      predReturnD <= 1'b0;
    else if (~StallD)
      predReturnD <= PredReturnF;
  end

  always_ff @(posedge clk) begin
    if (rst | FlushE)
      ClassE <= 4'b0000;
    else if (~StallE)
      ClassE <= ClassD;
  end

  always_ff @(posedge clk) begin
    if (rst | FlushM)
      ClassM <= 4'b0000;
    else if (~StallM)
      ClassM <= ClassE;
  end

  // Single pulse as the instruction leaves D, so the stack undoes one pop only
  assign ReturnWrongD = InstrValidD & predReturnD & ~returnD & ~StallD;

  assert property (@(posedge clk) disable iff (rst) $onehot0(ClassE))
    else $error("ClassE holds more than one class: %b", ClassE);

endmodule

// ==== hw/returnStack.sv ====
// Empty stack reads address zero; only one outstanding wrong pop can be undone, push not stall-gated
`timescale 1ns/1ps

module returnStack #(
  parameter int RasDepth = 4
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         StallD,
  input  logic         PredReturnF,
  input  logic         ReturnWrongD,
  input  logic         CallE,
  input  logic         InstrValidE,
  input  bpredPkg::pcT PCLinkE,
  output bpredPkg::pcT RASPCF
);
  import bpredPkg::*;

  localparam int PtrBits = (RasDepth > 1) ? $clog2(RasDepth) : 1;
  localparam logic [PtrBits-1:0] LastPtr = PtrBits'(RasDepth - 1);

  pcT                 stackMem [RasDepth];
  logic [PtrBits-1:0] top;
  logic [PtrBits-1:0] baseTop;
  logic [PtrBits-1:0] nextTop;
  logic [PtrBits-1:0] writePtr;
  logic               popF;
  logic               pushE;

  // Circular pointer steps
  function automatic logic [PtrBits-1:0] incPtr(input logic [PtrBits-1:0] p);
    return (p == LastPtr) ? '0 : p + 1'b1;
  endfunction

  function automatic logic [PtrBits-1:0] decPtr(input logic [PtrBits-1:0] p);
    return (p == '0) ? LastPtr : p - 1'b1;
  endfunction

  assign popF  = PredReturnF & ~StallD;
  assign pushE = CallE & InstrValidE;

  // Undo the wrong pop before applying this cycle's push or pop
  assign baseTop = ReturnWrongD ? incPtr(top) : top;

  always_comb begin
    writePtr = incPtr(baseTop);
    nextTop  = baseTop;
    if (pushE & popF) begin
      // Replace top in place
      writePtr = baseTop;
    end else if (pushE) begin
      nextTop = incPtr(baseTop);
    end else if (popF) begin
      nextTop = decPtr(baseTop);
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      top <= LastPtr;
    else
      top <= nextTop;
  end

  // Oldest entry is overwritten once the pointer wraps
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < RasDepth; i++) begin
        stackMem[i] <= '0;
      end
    end else if (pushE) begin
      stackMem[writePtr] <= PCLinkE;
    end
  end

  assign RASPCF = stackMem[top];

  assert property (@(posedge clk) disable iff (rst) top <= LastPtr)
    else $error("Return stack pointer out of range: %0d", top);

endmodule

// ==== hw/targetBuffer.sv ====
// Target pipe to E advances on StallF, so F, D and E must stall together; no replacement policy
`timescale 1ns/1ps

module targetBuffer #(
  parameter int BtbBits = 4
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         StallF,
  input  bpredPkg::pcT PCNextF,
  input  bpredPkg::pcT PCF,
  input  bpredPkg::pcT PCE,
  input  bpredPkg::pcT IEUAdrE,
  input  logic [3:0]   ClassE,
  input  logic         InstrValidE,
  input  logic         PCSrcE,
  output bpredPkg::pcT BPBTAF,
  output logic [3:0]   BTBClassF,
  output logic         TargetWrongE
);
  import bpredPkg::*;

  localparam int Entries = 1 << BtbBits;
  localparam int TagBits = Xlen - BtbBits - 2;

  logic               validMem  [Entries];
  logic [TagBits-1:0] tagMem    [Entries];
  pcT                 targetMem [Entries];
  logic [3:0]         classMem  [Entries];

  logic [BtbBits-1:0] idxNextF;
  logic [BtbBits-1:0] idxE;
  logic               validF;
  logic [TagBits-1:0] tagF;
  pcT                 targetF;
  logic [3:0]         classF;
  logic               hitF;
  pcT                 targetD;
  pcT                 targetE;
  logic               writeE;

  assign idxNextF = PCNextF[BtbBits+1:2];
  assign idxE     = PCE[BtbBits+1:2];

  ////////////////////////////////////////
  // Update from E
  ////////////////////////////////////////

  // Any taken control transfer installs or refreshes its entry
  assign writeE = InstrValidE & PCSrcE & (ClassE != 4'b0000);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < Entries; i++) begin
        validMem[i] <= 1'b0;
      end
    end else if (writeE) begin
      validMem[idxE] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (writeE) begin
      tagMem[idxE]    <= PCE[Xlen-1:BtbBits+2];
      targetMem[idxE] <= IEUAdrE;
      classMem[idxE]  <= ClassE;
    end
  end

  ////////////////////////////////////////
  // Fetch lookup
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst)
      validF <= 1'b0;
    else if (~StallF)
      validF <= validMem[idxNextF];
  end

  always_ff @(posedge clk) begin
    if (~StallF) begin
      tagF    <= tagMem[idxNextF];
      targetF <= targetMem[idxNextF];
      classF  <= classMem[idxNextF];
    end
  end

  // Tag was read for PCNextF, checked against what is now PCF
  assign hitF      = validF & (tagF == PCF[Xlen-1:BtbBits+2]);
  assign BPBTAF    = targetF;
  assign BTBClassF = hitF ? classF : 4'b0000;

  // Predicted target follows the instruction to E, zero on a miss
  always_ff @(posedge clk) begin
    if (~StallF) begin
      targetD <= hitF ? targetF : '0;
      targetE <= targetD;
    end
  end

  // Returns are judged by the stack, not here
  assign TargetWrongE = writeE & ~ClassE[ClassReturn] & (targetE != IEUAdrE);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f verilog.f \
  --top-module branchPredictorTb -Mdir "$BUILD_DIR" -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== sim/branchPredictorTb.sv ====
// Ideal F/D/E stream with no stalls except StallM and FlushM; fetch PCs are not the DUT's next PC
`timescale 1ns/1ps

module branchPredictorTb;
  import bpredPkg::*;

  localparam int DirBits    = 6;
  localparam int BtbBits    = 4;
  localparam int RasDepth   = 4;
  localparam int TagBits    = Xlen - BtbBits - 2;
  // About 120 issued cycles, so five times that is plenty
  localparam int MaxCycles  = 600;
  localparam logic [3:0] NoCls   = 4'b0000;
  localparam logic [3:0] CallCls = 4'b0001 << ClassCall;
  localparam logic [3:0] RetCls  = 4'b0001 << ClassReturn;
  localparam logic [3:0] JumpCls = 4'b0001 << ClassJump;
  localparam logic [3:0] BrCls   = 4'b0001 << ClassBranch;

  logic        clk, rst;
  logic        StallF, StallD, StallE, StallM, FlushD, FlushE, FlushM;
  logic [31:0] InstrD;
  logic        InstrValidD, InstrValidE, PCSrcE;
  pcT          PCNextF, PCPlus4F, PCF, PCD, PCE, IEUAdrE, PCLinkE, PC1NextF;
  logic        BPWrongE, BPWrongM, BPDirPredWrongM, BTAWrongM, ClassWrongM;
  logic [3:0]  ClassM;
  logic [3:0]  mFlags;

  // Stream slots: 0 next fetch, 1 F, 2 D, 3 E
  pcT          sPc  [4];
  logic [3:0]  sCls [4];
  logic        sTkn [4];
  pcT          sTgt [4];

  // Reference tables
  logic               bV   [1 << BtbBits];
  logic [TagBits-1:0] bTag [1 << BtbBits];
  pcT                 bTgt [1 << BtbBits];
  logic [3:0]         bCls [1 << BtbBits];
  logic [1:0]         ctr  [1 << DirBits];
  pcT                 rasMem [RasDepth];
  int                 rasCnt;
  logic               fV;
  logic [TagBits-1:0] fTag;
  pcT                 fTgt;
  logic [3:0]         fCls;
  logic [1:0]         fCtr;
  logic               dirD, dirE, mWrong, mDir;
  // Predicted target and class carried from F to E
  pcT                 tgtD, tgtE;
  logic [3:0]         pClsD, pClsE;
  logic               mTgt, mClsWrong;
  logic [3:0]         mClass;

  logic [3:0] clsF;
  logic       fHit, takeF, pushE, popF, expWrong, expDirWrong, expTgtWrong, expClsWrong;
  pcT         rasTop, corrE, expNext;
  logic [31:0] lfsr = 32'hf0fe_836d;
  int          cycles = 0;
  int          wrongSeen = 0;
  int          redirectSeen = 0;
  int          dirWrongSeen = 0;

  tbClock #(.Period(8), .ResetCycles(2)) i_tbClock (.clk, .rst);

  branchPredictor #(.DirBits(DirBits), .BtbBits(BtbBits), .RasDepth(RasDepth))
    i_branchPredictor (.*);

  assign mFlags = {BPWrongM, BPDirPredWrongM, BTAWrongM, ClassWrongM};

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on error");
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randomBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Smallest RV32 word of each class
  function automatic logic [31:0] encodeInstr(input logic [3:0] cls);
    case (cls)
      CallCls: return 32'h0000_00ef;
      RetCls:  return 32'h0000_8067;
      JumpCls: return 32'h0000_006f;
      BrCls:   return 32'h0000_0063;
      default: return 32'h0000_0013;
    endcase
  endfunction

  ////////////////////////////////////////
  // Stimulus stream
  ////////////////////////////////////////

  // Shift the stream one stage and drive all stages on the falling edge
  task automatic issue(input pcT pc, input logic [3:0] cls, input logic tkn, input pcT tgt,
                       input logic vd);
    @(negedge clk);
    for (int i = 3; i > 0; i--) begin
      sPc[i]  = sPc[i-1];
      sCls[i] = sCls[i-1];
      sTkn[i] = sTkn[i-1];
      sTgt[i] = sTgt[i-1];
    end
    sPc[0]      = pc;
    sCls[0]     = cls;
    sTkn[0]     = tkn;
    sTgt[0]     = tgt;
    PCNextF     = sPc[0];
    PCF         = sPc[1];
    PCPlus4F    = sPc[1] + 32'd4;
    PCD         = sPc[2];
    InstrD      = encodeInstr(sCls[2]);
    InstrValidD = vd;
    PCE         = sPc[3];
    PCSrcE      = sTkn[3];
    IEUAdrE     = sTgt[3];
    PCLinkE     = sPc[3] + 32'd4;
    InstrValidE = 1'b1;
  endtask

  // Filler PCs live above 0x10000, so they never hit a real entry
  task automatic issueNop(input logic vd);
    logic [31:0] r;
    randomBits(14, r);
    issue(32'h0001_0000 | {r[29:0], 2'b00}, NoCls, 1'b0, '0, vd);
  endtask

  task automatic issueGap(input int n);
    repeat (n) issueNop(1'b0);
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  always_comb begin
    rasTop      = (rasCnt > 0) ? rasMem[rasCnt-1] : '0;
    fHit        = fV && fTag == PCF[Xlen-1:BtbBits+2];
    clsF        = fHit ? fCls : NoCls;
    takeF       = (|clsF[3:1]) || (clsF[ClassBranch] && fCtr[1]);
    corrE       = PCSrcE ? IEUAdrE : PCLinkE;
    expWrong    = InstrValidE && InstrValidD && (corrE != PCD);
    expDirWrong = InstrValidE && sCls[3][ClassBranch] && (dirE != PCSrcE);
    // Taken non-return transfer that went somewhere other than the predicted target
    expTgtWrong = InstrValidE && PCSrcE && sCls[3] != NoCls && !sCls[3][ClassReturn]
                  && (tgtE != IEUAdrE);
    expClsWrong = InstrValidE && (pClsE != sCls[3]);
    pushE       = InstrValidE && sCls[3][ClassCall];
    popF        = clsF[ClassReturn];
    if (expWrong)
      expNext = corrE;
    else if (takeF)
      expNext = clsF[ClassReturn] ? rasTop : fTgt;
    else
      expNext = PCPlus4F;
  end

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < (1 << BtbBits); i++) begin
        bV[i] <= 1'b0;
      end
      for (int i = 0; i < (1 << DirBits); i++) begin
        ctr[i] <= 2'd1;
      end
      rasCnt    <= 0;
      fV        <= 1'b0;
      fCtr      <= 2'd1;
      dirD      <= 1'b0;
      dirE      <= 1'b0;
      tgtD      <= '0;
      tgtE      <= '0;
      pClsD     <= NoCls;
      pClsE     <= NoCls;
      mWrong    <= 1'b0;
      mDir      <= 1'b0;
      mTgt      <= 1'b0;
      mClsWrong <= 1'b0;
      mClass    <= NoCls;
    end else begin
      // Lookup sees the tables as they were before this edge
      fV   <= bV[PCNextF[BtbBits+1:2]];
      fTag <= bTag[PCNextF[BtbBits+1:2]];
      fTgt <= bTgt[PCNextF[BtbBits+1:2]];
      fCls <= bCls[PCNextF[BtbBits+1:2]];
      fCtr <= ctr[PCNextF[DirBits+1:2]];
      dirD <= fCtr[1];
      dirE <= dirD;
      // Zero target when F missed
      tgtD  <= fHit ? fTgt : '0;
      tgtE  <= tgtD;
      pClsD <= clsF;
      pClsE <= pClsD;
      if (InstrValidE && PCSrcE && sCls[3] != NoCls) begin
        bV[PCE[BtbBits+1:2]]   <= 1'b1;
        bTag[PCE[BtbBits+1:2]] <= PCE[Xlen-1:BtbBits+2];
        bTgt[PCE[BtbBits+1:2]] <= IEUAdrE;
        bCls[PCE[BtbBits+1:2]] <= sCls[3];
      end
      // Saturating step toward the outcome
      if (InstrValidE && sCls[3][ClassBranch]) begin
        if (PCSrcE && ctr[PCE[DirBits+1:2]] != 2'd3)
          ctr[PCE[DirBits+1:2]] <= ctr[PCE[DirBits+1:2]] + 2'd1;
        else if (!PCSrcE && ctr[PCE[DirBits+1:2]] != 2'd0)
          ctr[PCE[DirBits+1:2]] <= ctr[PCE[DirBits+1:2]] - 2'd1;
      end
      // Stack as a list, oldest dropped at the bottom when full
      if (pushE && popF && rasCnt > 0) begin
        rasMem[rasCnt-1] <= PCLinkE;
      end else if (pushE && rasCnt == RasDepth) begin
        for (int i = 0; i < RasDepth - 1; i++) begin
          rasMem[i] <= rasMem[i+1];
        end
        rasMem[RasDepth-1] <= PCLinkE;
      end else if (pushE) begin
        rasMem[rasCnt] <= PCLinkE;
        rasCnt         <= rasCnt + 1;
      end else if (popF && rasCnt > 0) begin
        rasCnt <= rasCnt - 1;
      end
      if (FlushM) begin
        mWrong    <= 1'b0;
        mDir      <= 1'b0;
        mTgt      <= 1'b0;
        mClsWrong <= 1'b0;
        mClass    <= NoCls;
      end else if (!StallM) begin
        mWrong    <= expWrong;
        mDir      <= expDirWrong;
        mTgt      <= expTgtWrong;
        mClsWrong <= expClsWrong;
        mClass    <= sCls[3];
      end
      if (expWrong)
        wrongSeen <= wrongSeen + 1;
      if (takeF)
        redirectSeen <= redirectSeen + 1;
      if (mDir)
        dirWrongSeen <= dirWrongSeen + 1;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  assert property (@(posedge clk) disable iff (rst) PC1NextF == expNext)
    else abortRun($sformatf("MISMATCH at %0t: PC1NextF %h, expected %h", $time,
                            $sampled(PC1NextF), $sampled(expNext)));

  assert property (@(posedge clk) disable iff (rst) BPWrongE == expWrong)
    else abortRun($sformatf("MISMATCH at %0t: BPWrongE %b, expected %b", $time,
                            $sampled(BPWrongE), $sampled(expWrong)));

  assert property (@(posedge clk) disable iff (rst) BPWrongM == mWrong)
    else abortRun($sformatf("MISMATCH at %0t: BPWrongM %b, expected %b", $time,
                            $sampled(BPWrongM), $sampled(mWrong)));

  assert property (@(posedge clk) disable iff (rst) BPDirPredWrongM == mDir)
    else abortRun($sformatf("MISMATCH at %0t: BPDirPredWrongM %b, expected %b", $time,
                            $sampled(BPDirPredWrongM), $sampled(mDir)));

  assert property (@(posedge clk) disable iff (rst) BTAWrongM == mTgt)
    else abortRun($sformatf("MISMATCH at %0t: BTAWrongM %b, expected %b", $time,
                            $sampled(BTAWrongM), $sampled(mTgt)));

  assert property (@(posedge clk) disable iff (rst) ClassWrongM == mClsWrong)
    else abortRun($sformatf("MISMATCH at %0t: ClassWrongM %b, expected %b", $time,
                            $sampled(ClassWrongM), $sampled(mClsWrong)));

  assert property (@(posedge clk) disable iff (rst) ClassM == mClass)
    else abortRun($sformatf("MISMATCH at %0t: ClassM %b, expected %b", $time,
                            $sampled(ClassM), $sampled(mClass)));

  // M report holds under stall, flush clears it
  assert property (@(posedge clk) disable iff (rst)
                   (StallM && !FlushM) |=> mFlags == $past(mFlags))
    else abortRun($sformatf("MISMATCH at %0t: M flags %b changed while StallM was high",
                            $time, $sampled(mFlags)));

  assert property (@(posedge clk) disable iff (rst) FlushM |=> mFlags == 4'b0000)
    else abortRun($sformatf("MISMATCH at %0t: M flags %b after FlushM, expected 0000",
                            $time, $sampled(mFlags)));

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles)
      abortRun($sformatf("Timeout after %0d cycles, stimulus did not finish", cycles));
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    {StallF, StallD, StallE, StallM} = 4'b0000;
    {FlushD, FlushE, FlushM}         = 3'b000;
    InstrD      = 32'h0000_0013;
    InstrValidD = 1'b0;
    InstrValidE = 1'b0;
    PCSrcE      = 1'b0;
    PCNextF     = '0;
    PCPlus4F    = 32'd4;
    PCF         = '0;
    PCD         = '0;
    PCE         = '0;
    IEUAdrE     = '0;
    PCLinkE     = 32'd4;
    for (int i = 0; i < 4; i++) begin
      sPc[i]  = '0;
      sCls[i] = NoCls;
      sTkn[i] = 1'b0;
      sTgt[i] = '0;
    end
    wait (!rst);

    // Empty tables fall through
    issueGap(24);
    // Sequential pair is fine, random D successor is a mispredict
    issue(32'h0000_0400, NoCls, 1'b0, '0, 1'b0);
    issue(32'h0000_0404, NoCls, 1'b0, '0, 1'b0);
    issueNop(1'b0);
    issueNop(1'b1);
    issueNop(1'b1);
    issueGap(3);

    // Taken jal, corrected in E, then predicted on refetch
    issue(32'h0000_1004, JumpCls, 1'b1, 32'h0000_2000, 1'b0);
    issueNop(1'b0);
    issueNop(1'b0);
    issueNop(1'b1);
    issueGap(3);
    issue(32'h0000_1004, JumpCls, 1'b1, 32'h0000_2000, 1'b0);
    issueGap(4);

    // Counter climbs on taken and falls back on not taken
    repeat (2) begin
      issue(32'h0000_1108, BrCls, 1'b1, 32'h0000_1200, 1'b0);
      issueGap(4);
    end
    repeat (3) begin
      issue(32'h0000_1108, BrCls, 1'b0, 32'h0000_1200, 1'b0);
      issueGap(4);
    end

    // Nested calls, return learned once, then popped in LIFO order
    issue(32'h0000_130c, CallCls, 1'b1, 32'h0000_3000, 1'b0);
    issueGap(4);
    issue(32'h0000_3814, RetCls, 1'b1, 32'h0000_1310, 1'b0);
    issueGap(4);
    issue(32'h0000_1410, CallCls, 1'b1, 32'h0000_3400, 1'b0);
    issueGap(4);
    issue(32'h0000_3814, RetCls, 1'b1, 32'h0000_1414, 1'b0);
    issueGap(4);
    issue(32'h0000_3814, RetCls, 1'b1, 32'h0000_1310, 1'b0);
    issueGap(4);

    // M report held by StallM, then cleared by FlushM
    issueNop(1'b1);
    issueNop(1'b0);
    StallM = 1'b1;
    issueNop(1'b1);
    issueNop(1'b1);
    issueNop(1'b0);
    FlushM = 1'b1;
    issueNop(1'b0);
    FlushM = 1'b0;
    StallM = 1'b0;
    issueGap(4);

    if (wrongSeen == 0 || redirectSeen == 0 || dirWrongSeen == 0) begin
      abortRun("Stimulus never produced a mispredict, a predicted redirect or a direction miss");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// ==== sim/tbClock.sv ====
// Free-running clock from time zero; reset is released on a falling edge after ResetCycles rising edges
`timescale 1ns/1ps

module tbClock #(
  parameter int Period      = 8,
  parameter int ResetCycles = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    // Hold reset over the first rising edges, then let go between edges
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

  always #(Period / 2) clk = ~clk;

endmodule

// ==== verilog.f ====
hw/bpredPkg.sv
hw/instrClassDecode.sv
hw/dirPredictor.sv
hw/targetBuffer.sv
hw/returnStack.sv
hw/branchPredictor.sv
sim/tbClock.sv
sim/branchPredictorTb.sv
